// File: exe_core.f
+incdir+verilog
verilog/exe_pkg.sv
verilog/exe_if.sv
verilog/exe_alu.sv
verilog/exe_divider.sv
verilog/exe_regfile.sv
verilog/execute_stage.sv
verilog/exe_top.sv
sim/exe_assertions.sv
sim/exe_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module exe_tb -f exe_core.f -Mdir obj_dir
./obj_dir/Vexe_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

// File: sim/exe_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

module exe_tb;
    import exe_pkg::*;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
    } wb_exp_t;

    logic        clk;
    logic        rst;
    logic        in_valid;
    exe_op_u     in_op;
    logic [4:0]  in_rd;
    logic [4:0]  in_rs1;
    logic [4:0]  in_rs2;
    logic [31:0] in_imm;
    logic        credit_return;
    logic        wb_valid;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic [31:0] regs [32];   // architectural state of the model
    wb_exp_t     expect_q [$];
    int          credits;
    int          errors;
    int          issued;
    int          retired;
    bit          hung;

    exe_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic exe_op_u alu_word(input exe_alu_op_e f, input logic use_imm);
        exe_op_u w;
        w = '0;
        w.alu_view.unit    = EXE_UNIT_ALU;
        w.alu_view.use_imm = use_imm;
        w.alu_view.op      = f;
        return w;
    endfunction

    function automatic exe_op_u div_word(input logic sgn, input logic rem);
        exe_op_u w;
        w = '0;
        w.div_view.unit      = EXE_UNIT_DIV;
        w.div_view.is_signed = sgn;
        w.div_view.want_rem  = rem;
        return w;
    endfunction

    function automatic logic [31:0] predict(input exe_op_u op, input logic [31:0] a,
                                            input logic [31:0] b, input logic [31:0] imm);
        logic [31:0] rhs;
        logic        rem;
        rhs = op.alu_view.use_imm ? imm : b;
        rem = op.div_view.want_rem;
        if (op.div_view.unit == EXE_UNIT_DIV) begin
            if (b == '0) begin
                return rem ? a : '1;
            end else if (op.div_view.is_signed && a == 32'h8000_0000 && b == '1) begin
                return rem ? '0 : a;   // signed overflow
            end else if (op.div_view.is_signed) begin
                return rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
            end
            return rem ? a % b : a / b;
        end
        case (op.alu_view.op)
            ALU_ADD:  return a + rhs;
            ALU_SUB:  return a - rhs;
            ALU_SLL:  return a << rhs[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(rhs)};
            ALU_SLTU: return {31'b0, a < rhs};
            ALU_XOR:  return a ^ rhs;
            ALU_SRL:  return a >> rhs[4:0];
            ALU_SRA:  return $signed(a) >>> rhs[4:0];
            ALU_OR:   return a | rhs;
            ALU_AND:  return a & rhs;
            default:  return '0;
        endcase
    endfunction

    // waits for a credit, then drives one operation and records its result
    task automatic issue_op(input exe_op_u op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input logic [31:0] imm);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        while (credits == 0 && !hung) begin
            waited++;
            if (waited > 200) begin
                $display("timeout: no credit came back within 200 cycles");
                errors++;
                hung = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        if (!hung) begin
            in_valid = 1'b1;
            in_op    = op;
            in_rd    = rd;
            in_rs1   = rs1;
            in_rs2   = rs2;
            in_imm   = imm;
            expect_q.push_back({rd, predict(op, regs[rs1], regs[rs2], imm)});
            if (rd != '0) begin
                regs[rd] = expect_q[$].data;
            end
            issued++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            credits <= `EXE_CREDITS;
        end else begin
            credits <= credits + int'(credit_return) - int'(in_valid);
            if (wb_valid) begin
                retired++;
                assert (expect_q.size() != 0) else begin
                    $display("Error: %0t ns: writeback to x%0d with nothing issued", $time, wb_rd);
                    errors++;
                end
                if (expect_q.size() != 0) begin
                    assert (expect_q[0] == {wb_rd, wb_data}) else begin
                        $display("Error: %0t ns: got x%0d=%h, expected x%0d=%h", $time,
                                 wb_rd, wb_data, expect_q[0].rd, expect_q[0].data);
                        errors++;
                    end
                    void'(expect_q.pop_front());
                end
            end
        end
    end

    initial begin
        int         waited;
        int         dep;
        logic [4:0] prev_rd;
        exe_op_u    op;
        void'($urandom(32'h3dcb91ca));
        rst      = 1'b0;
        in_valid = 1'b0;
        in_op    = '0;
        in_rd    = '0;
        in_rs1   = '0;
        in_rs2   = '0;
        in_imm   = '0;
        errors   = 0;
        issued   = 0;
        retired  = 0;
        hung     = 1'b0;
        prev_rd  = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (6) @(posedge clk);   // no writeback expected while idle
        for (int r = 1; r < 32; r++) begin
            issue_op(alu_word(ALU_ADD, 1'b1), 5'(r), 5'd0, 5'd0, $urandom());
        end
        issue_op(alu_word(ALU_ADD, 1'b1), 5'd1, 5'd0, 5'd0, 32'h8000_0000);
        issue_op(alu_word(ALU_ADD, 1'b1), 5'd2, 5'd0, 5'd0, 32'hffff_ffff);
        issue_op(alu_word(ALU_ADD, 1'b1), 5'd3, 5'd0, 5'd0, 32'd0);
        for (int k = 0; k < 4; k++) begin
            issue_op(div_word(k[1], k[0]), 5'd10, 5'd1, 5'd2, '0);   // min by -1
            issue_op(div_word(k[1], k[0]), 5'd11, 5'd4, 5'd3, '0);   // by zero
            issue_op(div_word(k[1], k[0]), 5'd12, 5'd4, 5'd5, '0);
            issue_op(alu_word(ALU_XOR, 1'b0), 5'd13, 5'd12, 5'd6, '0);
        end
        for (int f = 0; f < 10; f++) begin
            issue_op(alu_word(exe_alu_op_e'(4'(f)), 1'b0), 5'd7, 5'd5, 5'd6, '0);
            issue_op(alu_word(exe_alu_op_e'(4'(f)), 1'b1), 5'd8, 5'd7, 5'd0, $urandom());
            issue_op(alu_word(exe_alu_op_e'(4'(f)), 1'b0), 5'd0, 5'd9, 5'd8, '0);
            issue_op(alu_word(ALU_OR, 1'b0), 5'd14, 5'd0, 5'd0, '0);   // x0 stays zero
        end
        for (int n = 0; n < 300; n++) begin
            if ($urandom_range(0, 3) == 0) begin
                op = div_word(1'($urandom_range(0, 1)), 1'($urandom_range(0, 1)));
            end else begin
                op = alu_word(exe_alu_op_e'(4'($urandom_range(0, 9))),
                              1'($urandom_range(0, 1)));
            end
            dep = $urandom_range(0, 2);   // 1 and 2 read the previous rd
            issue_op(op, 5'($urandom_range(0, 31)),
                     dep == 1 ? prev_rd : 5'($urandom_range(0, 31)),
                     dep == 2 ? prev_rd : 5'($urandom_range(0, 31)), $urandom());
            prev_rd = in_rd;
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        waited   = 0;
        while (expect_q.size() != 0 && !hung) begin
            waited++;
            if (waited > 200) begin
                $display("timeout: %0d results never came back", expect_q.size());
                errors++;
                hung = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        repeat (6) @(posedge clk);
        assert (issued == retired) else begin
            $display("Error: %0t ns: %0d issued but %0d results", $time, issued, retired);
            errors++;
        end
        $display("issued %0d, results %0d, errors %0d", issued, retired, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/exe_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

module exe_credit_assertions (
    input logic clk,
    input logic rst,
    input logic in_valid,
    input logic credit_return,
    input logic wb_valid
);
    logic [2:0] credits;   // producer credits as seen on the ports

    always_ff @(posedge clk) begin
        if (!rst) begin
            credits <= 3'(`EXE_CREDITS);
        end else begin
            credits <= credits + {2'b0, credit_return} - {2'b0, in_valid};
        end
    end

    no_over_issue: assert property (@(posedge clk) disable iff (!rst)
        in_valid |-> credits != '0)
        else $error("in_valid raised with no credit left");

    credit_follows_wb: assert property (@(posedge clk) disable iff (!rst)
        credit_return == wb_valid)
        else $error("credit_return and wb_valid differ");

    quiet_after_reset: assert property (@(posedge clk) !rst |=> !wb_valid && !credit_return)
        else $error("writeback active right after reset");

endmodule

bind exe_top exe_credit_assertions credit_chk_i (
    .clk(clk), .rst(rst), .in_valid(in_valid),
    .credit_return(credit_return), .wb_valid(wb_valid)
);

`default_nettype wire

// File: verilog/exe_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

module exe_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  exe_pkg::exe_op_u              in_op,
    input  logic [$clog2(`EXE_NREGS)-1:0] in_rd,
    input  logic [$clog2(`EXE_NREGS)-1:0] in_rs1,
    input  logic [$clog2(`EXE_NREGS)-1:0] in_rs2,
    input  logic [`EXE_XLEN-1:0]          in_imm,
    output logic                          credit_return,
    output logic                          wb_valid,
    output logic [$clog2(`EXE_NREGS)-1:0] wb_rd,
    output logic [`EXE_XLEN-1:0]          wb_data
);
    import exe_pkg::*;

    exe_entry_t                    in_entry;
    logic [$clog2(`EXE_NREGS)-1:0] rs1;
    logic [$clog2(`EXE_NREGS)-1:0] rs2;
    logic [`EXE_XLEN-1:0]          rdata1;
    logic [`EXE_XLEN-1:0]          rdata2;
    logic [`EXE_XLEN-1:0]          alu_a;
    logic [`EXE_XLEN-1:0]          alu_b;
    exe_alu_op_e                   alu_op;
    logic [`EXE_XLEN-1:0]          alu_result;

    div_if div_bus ();
    wb_if  wb_bus ();

    assign in_entry = '{op: in_op, rd: in_rd, rs1: in_rs1, rs2: in_rs2, imm: in_imm};

    execute_stage stage_i (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_entry(in_entry),
        .credit_return(credit_return), .rs1(rs1), .rs2(rs2),
        .rdata1(rdata1), .rdata2(rdata2), .alu_a(alu_a), .alu_b(alu_b),
        .alu_op(alu_op), .alu_result(alu_result), .div(div_bus.master), .wb(wb_bus.source)
    );

    exe_alu alu_i (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

    exe_divider div_i (.clk(clk), .rst(rst), .div(div_bus.slave));

    exe_regfile rf_i (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
        .rdata1(rdata1), .rdata2(rdata2), .wb(wb_bus.sink)
    );

    assign wb_valid = wb_bus.valid;
    assign wb_rd    = wb_bus.rd;
    assign wb_data  = wb_bus.data;

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

module execute_stage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          in_valid,
    input  exe_pkg::exe_entry_t           in_entry,
    output logic                          credit_return,
    output logic [$clog2(`EXE_NREGS)-1:0] rs1,
    output logic [$clog2(`EXE_NREGS)-1:0] rs2,
    input  logic [`EXE_XLEN-1:0]          rdata1,
    input  logic [`EXE_XLEN-1:0]          rdata2,
    output logic [`EXE_XLEN-1:0]          alu_a,
    output logic [`EXE_XLEN-1:0]          alu_b,
    output exe_pkg::exe_alu_op_e          alu_op,
    input  logic [`EXE_XLEN-1:0]          alu_result,
    div_if.master                         div,
    wb_if.source                          wb
);
    import exe_pkg::*;

    localparam int QW = (`EXE_CREDITS > 1) ? $clog2(`EXE_CREDITS) : 1;
    localparam logic [QW-1:0] Q_LAST = QW'(`EXE_CREDITS - 1);

    exe_entry_t              q_entry [`EXE_CREDITS];
    logic [`EXE_CREDITS-1:0] q_valid;
    logic [QW-1:0]           head_ptr;
    logic [QW-1:0]           tail_ptr;
    exe_entry_t              head;
    logic                    head_valid;
    logic                    head_is_div;
    logic                    div_wait;   // head divide has been started
    logic                    issue_alu;
    logic                    finish_div;
    logic                    pop;

    function automatic logic [QW-1:0] next_ptr(input logic [QW-1:0] ptr);
        return (ptr == Q_LAST) ? '0 : ptr + QW'(1);
    endfunction

    assign head        = q_entry[head_ptr];
    assign head_valid  = q_valid[head_ptr];
    assign head_is_div = head.op.div_view.unit == EXE_UNIT_DIV;

    assign rs1    = head.rs1;
    assign rs2    = head.rs2;
    assign alu_a  = rdata1;
    assign alu_b  = head.op.alu_view.use_imm ? head.imm : rdata2;
    assign alu_op = head.op.alu_view.op;

    assign div.dividend  = rdata1;
    assign div.divisor   = rdata2;
    assign div.is_signed = head.op.div_view.is_signed;
    assign div.want_rem  = head.op.div_view.want_rem;
    assign div.start     = head_valid & head_is_div & ~div_wait & ~div.busy;

    assign issue_alu  = head_valid & ~head_is_div;
    assign finish_div = head_valid & head_is_div & div_wait & div.done; // head stalls until here
    assign pop        = issue_alu | finish_div;

    always_ff @(posedge clk) begin
        if (!rst) begin
            q_valid  <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            div_wait <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            if (pop) begin
                q_valid[head_ptr] <= 1'b0;
                head_ptr          <= next_ptr(head_ptr);
            end
            if (in_valid) begin // credits guarantee a free slot
                q_valid[tail_ptr] <= 1'b1;
                tail_ptr          <= next_ptr(tail_ptr);
            end
            if (div.start) begin
                div_wait <= 1'b1;
            end else if (finish_div) begin
                div_wait <= 1'b0;
            end
            wb.valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            q_entry[tail_ptr] <= in_entry;
        end
        if (pop) begin
            wb.rd   <= head.rd;
            wb.data <= head_is_div ? div.result : alu_result;
        end
    end

    assign credit_return = wb.valid; // one credit per retired result

endmodule

`default_nettype wire

// File: verilog/exe_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

module exe_regfile (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [$clog2(`EXE_NREGS)-1:0] rs1,
    input  logic [$clog2(`EXE_NREGS)-1:0] rs2,
    output logic [`EXE_XLEN-1:0]          rdata1,
    output logic [`EXE_XLEN-1:0]          rdata2,
    wb_if.sink                            wb
);
    logic [`EXE_XLEN-1:0] regs [`EXE_NREGS];
    logic                 wr_en;
    logic                 hit1;
    logic                 hit2;

    assign wr_en = wb.valid & (wb.rd != '0); // x0 never written

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `EXE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // same-cycle bypass, so a dependent op can read right behind its producer
    assign hit1 = wr_en & (wb.rd == rs1);
    assign hit2 = wr_en & (wb.rd == rs2);

    assign rdata1 = hit1 ? wb.data : regs[rs1];
    assign rdata2 = hit2 ? wb.data : regs[rs2];

endmodule

`default_nettype wire

// File: verilog/exe_divider.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

module exe_divider (
    input logic clk,
    input logic rst,
    div_if.slave div
);
    localparam int CW = $clog2(`EXE_DIV_STEPS + 1);

    logic [CW-1:0]        count;
    logic [`EXE_XLEN-1:0] quot;   // dividend shifts out, quotient shifts in
    logic [`EXE_XLEN-1:0] rem;
    logic [`EXE_XLEN-1:0] dsor;
    logic                 neg_q;
    logic                 neg_r;
    logic                 rem_sel;
    logic                 a_neg;
    logic                 b_neg;
    logic                 accept;
    logic [`EXE_XLEN:0]   shifted;
    logic [`EXE_XLEN:0]   diff;

    assign accept  = div.start & ~div.busy;
    assign a_neg   = div.is_signed & div.dividend[`EXE_XLEN-1];
    assign b_neg   = div.is_signed & div.divisor[`EXE_XLEN-1];
    assign shifted = {rem, quot[`EXE_XLEN-1]};
    assign diff    = shifted - {1'b0, dsor};

    always_ff @(posedge clk) begin
        if (!rst) begin
            div.busy <= 1'b0;
            div.done <= 1'b0;
            count    <= '0;
        end else begin
            div.done <= 1'b0;
            if (accept) begin
                div.busy <= 1'b1;
                count    <= CW'(`EXE_DIV_STEPS);
            end else if (div.busy) begin
                count <= count - CW'(1);
                if (count == CW'(1)) begin // last iteration
                    div.busy <= 1'b0;
                    div.done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            quot    <= a_neg ? -div.dividend : div.dividend;
            dsor    <= b_neg ? -div.divisor : div.divisor;
            rem     <= '0;
            neg_q   <= (a_neg ^ b_neg) & (div.divisor != '0); // x/0 keeps all ones
            neg_r   <= a_neg;
            rem_sel <= div.want_rem;
        end else if (div.busy) begin
            if (!diff[`EXE_XLEN]) begin
                rem  <= diff[`EXE_XLEN-1:0];
                quot <= {quot[`EXE_XLEN-2:0], 1'b1};
            end else begin
                rem  <= shifted[`EXE_XLEN-1:0]; // restore
                quot <= {quot[`EXE_XLEN-2:0], 1'b0};
            end
        end
    end

    // min / -1 needs no special case, the magnitude path already yields min and 0
    assign div.result = rem_sel ? (neg_r ? -rem : rem) : (neg_q ? -quot : quot);

endmodule

`default_nettype wire

// File: verilog/exe_alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

module exe_alu (
    input  logic [`EXE_XLEN-1:0] a,
    input  logic [`EXE_XLEN-1:0] b,
    input  exe_pkg::exe_alu_op_e op,
    output logic [`EXE_XLEN-1:0] result
);
    import exe_pkg::*;

    localparam int SHW = $clog2(`EXE_XLEN);

    logic [SHW-1:0] shamt;

    assign shamt = b[SHW-1:0]; // low bits only, as rv32

    always_comb begin
        result = '0;
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0; // unused encodings
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/exe_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "exe_consts.svh"

interface div_if;
    logic                 start;   // single cycle, taken only while !busy
    logic                 is_signed;
    logic                 want_rem;
    logic [`EXE_XLEN-1:0] dividend;
    logic [`EXE_XLEN-1:0] divisor;
    logic                 busy;
    logic                 done;    // single cycle, result valid with it
    logic [`EXE_XLEN-1:0] result;

    modport master (output start, is_signed, want_rem, dividend, divisor,
                    input  busy, done, result);
    modport slave  (input  start, is_signed, want_rem, dividend, divisor,
                    output busy, done, result);
endinterface

interface wb_if;
    logic                          valid;
    logic [$clog2(`EXE_NREGS)-1:0] rd;
    logic [`EXE_XLEN-1:0]          data;

    modport source (output valid, rd, data);
    modport sink   (input  valid, rd, data);
endinterface

`default_nettype wire

// File: verilog/exe_pkg.sv
`default_nettype none

`include "exe_consts.svh"

package exe_pkg;

    typedef enum logic {
        EXE_UNIT_ALU = 1'b0,
        EXE_UNIT_DIV = 1'b1
    } exe_unit_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } exe_alu_op_e;

    typedef struct packed {
        exe_unit_e   unit;      // same bit position in both views
        logic        use_imm;   // imm replaces rs2 data
        logic [1:0]  spare;
        exe_alu_op_e op;
    } exe_alu_view_t;

    typedef struct packed {
        exe_unit_e  unit;
        logic       is_signed;
        logic       want_rem;   // remainder instead of quotient
        logic [4:0] spare;
    } exe_div_view_t;

    typedef union packed {
        exe_alu_view_t alu_view;
        exe_div_view_t div_view;
    } exe_op_u;

    typedef struct packed {
        exe_op_u                        op;
        logic [$clog2(`EXE_NREGS)-1:0]  rd;
        logic [$clog2(`EXE_NREGS)-1:0]  rs1;
        logic [$clog2(`EXE_NREGS)-1:0]  rs2;
        logic [`EXE_XLEN-1:0]           imm;
    } exe_entry_t;

endpackage

`default_nettype wire

// File: verilog/exe_consts.svh
`ifndef EXE_CONSTS_SVH
`define EXE_CONSTS_SVH

// data path width
`define EXE_XLEN 32

// architectural registers, x0 hardwired to zero
`define EXE_NREGS 32

// operation queue depth, also the producer's credit count after reset
`define EXE_CREDITS 2

// one shift-subtract iteration per result bit
`define EXE_DIV_STEPS `EXE_XLEN

`endif
